//--- logic/led_mon_pkg.sv
`default_nettype none

package led_mon_pkg;

    // Display geometry.
    parameter int NUM_DIGITS = 32;
    parameter int DIGIT_W    = 5;
    parameter int SEG_W      = 8;
    parameter int FRAME_W    = 16;

    // AXI field widths.
    parameter int ID_W   = 4;
    parameter int ADDR_W = 32;
    parameter int LEN_W  = 8;
    parameter int DATA_W = 32;

    parameter logic [1:0] RESP_OKAY   = 2'b00;
    parameter logic [1:0] RESP_SLVERR = 2'b10;

    // One latched frame, headed for the store.
    typedef struct packed {
        logic               valid;
        logic [DIGIT_W-1:0] digit;
        logic [SEG_W-1:0]   seg;
    } seg_write_t;

    // Read address channel.
    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [ADDR_W-1:0] addr;
        logic [LEN_W-1:0]  len;
        logic [1:0]        burst;
    } axi_ar_t;

    // Read data channel.
    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [DATA_W-1:0] data;
        logic [1:0]        resp;
        logic              last;
    } axi_r_t;

endpackage

`default_nettype wire

//--- logic/shift_chain_capture.sv
`timescale 1ns/1ps
`default_nettype none

module shift_chain_capture #(
    parameter int SYNC_STAGES = 2
) (
    input  logic                    clk,
    input  logic                    SLAVE_RSTN,
    input  logic                    sck,
    input  logic                    ser,
    input  logic                    rck,
    output led_mon_pkg::seg_write_t seg_write
);

    // Bit positions of the pins inside the synchronizer.
    localparam int PIN_SCK = 0;
    localparam int PIN_SER = 1;
    localparam int PIN_RCK = 2;

    logic [2:0]                          sync_q [SYNC_STAGES];
    logic [2:0]                          pins_s;
    logic                                sck_d;
    logic                                rck_d;
    logic                                sck_rise;
    logic                                rck_rise;
    logic [led_mon_pkg::FRAME_W-1:0]     chain;
    logic                                wr_valid;
    logic [led_mon_pkg::DIGIT_W-1:0]     wr_digit;
    logic [led_mon_pkg::SEG_W-1:0]       wr_seg;

    // All three pins share one synchronizer.
    always_ff @(posedge clk or negedge SLAVE_RSTN) begin
        if (!SLAVE_RSTN) begin
            for (int i = 0; i < SYNC_STAGES; i++) begin
                sync_q[i] <= '0;
            end
        end else begin
            sync_q[0] <= {rck, ser, sck};
            for (int i = 1; i < SYNC_STAGES; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
        end
    end

    assign pins_s = sync_q[SYNC_STAGES-1];

    always_ff @(posedge clk or negedge SLAVE_RSTN) begin
        if (!SLAVE_RSTN) begin
            sck_d <= 1'b0;
            rck_d <= 1'b0;
        end else begin
            sck_d <= pins_s[PIN_SCK];
            rck_d <= pins_s[PIN_RCK];
        end
    end

    assign sck_rise = pins_s[PIN_SCK] & ~sck_d;
    assign rck_rise = pins_s[PIN_RCK] & ~rck_d;

    // Two cascaded 595s.
    // New bit lands at bit 0, segment MSB spills into the select byte.
    always_ff @(posedge clk or negedge SLAVE_RSTN) begin
        if (!SLAVE_RSTN) begin
            chain <= '0;
        end else if (sck_rise) begin
            chain <= {chain[led_mon_pkg::FRAME_W-2:0], pins_s[PIN_SER]};
        end
    end

    always_ff @(posedge clk or negedge SLAVE_RSTN) begin
        if (!SLAVE_RSTN) begin
            wr_valid <= 1'b0;
        end else begin
            wr_valid <= rck_rise;
        end
    end

    // Storage latch.
    always_ff @(posedge clk) begin
        if (rck_rise) begin
            wr_digit <= chain[led_mon_pkg::SEG_W +: led_mon_pkg::DIGIT_W];
            wr_seg   <= chain[led_mon_pkg::SEG_W-1:0];
        end
    end

    assign seg_write = '{valid: wr_valid, digit: wr_digit, seg: wr_seg};

    // One write per rck rise.
    a_single_write: assert property (@(posedge clk) disable iff (!SLAVE_RSTN)
        seg_write.valid |=> !seg_write.valid);

endmodule

`default_nettype wire

//--- logic/digit_store.sv
`timescale 1ns/1ps
`default_nettype none

module digit_store (
    input  logic                            clk,
    input  logic                            SLAVE_RSTN,
    input  led_mon_pkg::seg_write_t         seg_write,
    input  logic [led_mon_pkg::DIGIT_W-1:0] rd_digit,
    output logic [led_mon_pkg::SEG_W-1:0]   rd_seg
);

    // Last pattern seen per digit.
    logic [led_mon_pkg::SEG_W-1:0] seg_mem [led_mon_pkg::NUM_DIGITS];

    always_ff @(posedge clk or negedge SLAVE_RSTN) begin
        if (!SLAVE_RSTN) begin
            for (int i = 0; i < led_mon_pkg::NUM_DIGITS; i++) begin
                seg_mem[i] <= '0;
            end
        end else if (seg_write.valid) begin
            seg_mem[seg_write.digit] <= seg_write.seg;
        end
    end

    // Live read with no register stage.
    assign rd_seg = seg_mem[rd_digit];

endmodule

`default_nettype wire

//--- logic/axi_rd_slave.sv
`timescale 1ns/1ps
`default_nettype none

module axi_rd_slave (
    input  logic                            clk,
    input  logic                            SLAVE_RSTN,
    input  led_mon_pkg::axi_ar_t            ar,
    input  logic                            ar_valid,
    output logic                            ar_ready,
    output led_mon_pkg::axi_r_t             r,
    output logic                            r_valid,
    input  logic                            r_ready,
    output logic [led_mon_pkg::DIGIT_W-1:0] rd_digit,
    input  logic [led_mon_pkg::SEG_W-1:0]   rd_seg
);

    localparam int PAD_W = led_mon_pkg::DATA_W - led_mon_pkg::DIGIT_W - led_mon_pkg::SEG_W;

    logic                           busy;
    logic [led_mon_pkg::LEN_W-1:0]  beat_cnt;
    logic [led_mon_pkg::ID_W-1:0]   id_q;
    logic [led_mon_pkg::ADDR_W-1:0] idx_q;
    logic [led_mon_pkg::LEN_W-1:0]  len_q;
    logic                           ar_fire;
    logic                           r_fire;
    logic                           last_beat;
    logic                           in_range;

    assign ar_fire   = ar_valid && ar_ready;
    assign r_fire    = r_valid && r_ready;
    assign last_beat = (beat_cnt == len_q);
    assign in_range  = (idx_q < led_mon_pkg::NUM_DIGITS);

    // Only one burst in flight.
    assign ar_ready = !busy;
    assign r_valid  = busy;

    always_ff @(posedge clk or negedge SLAVE_RSTN) begin
        if (!SLAVE_RSTN) begin
            busy     <= 1'b0;
            beat_cnt <= '0;
        end else if (ar_fire) begin
            busy     <= 1'b1;
            beat_cnt <= '0;
        end else if (r_fire) begin
            if (last_beat) begin
                busy <= 1'b0;
            end else begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    // Burst id, length and current word index.
    always_ff @(posedge clk) begin
        if (ar_fire) begin
            id_q  <= ar.id;
            idx_q <= ar.addr;
            len_q <= ar.len;
        end else if (r_fire && !last_beat) begin
            idx_q <= idx_q + 1'b1;
        end
    end

    assign rd_digit = idx_q[led_mon_pkg::DIGIT_W-1:0];

    always_comb begin
        r.id   = id_q;
        r.last = last_beat;
        if (in_range) begin
            r.data = {{PAD_W{1'b0}}, idx_q[led_mon_pkg::DIGIT_W-1:0], rd_seg};
            r.resp = led_mon_pkg::RESP_OKAY;
        end else begin
            // Past the last digit.
            r.data = '1;
            r.resp = led_mon_pkg::RESP_SLVERR;
        end
    end

    // Beat holds during a stall; the segment byte follows live writes.
    a_r_stable: assert property (@(posedge clk) disable iff (!SLAVE_RSTN)
        (r_valid && !r_ready) |=>
            ($stable(r.id) && $stable(r.resp) && $stable(r.last)
             && $stable(r.data[led_mon_pkg::DATA_W-1:led_mon_pkg::SEG_W])));

    // Burst stays open, and new requests blocked, until its last beat moves.
    a_burst_open: assert property (@(posedge clk) disable iff (!SLAVE_RSTN)
        (ar_fire || (r_valid && !(r_fire && r.last))) |=> (r_valid && !ar_ready));

endmodule

`default_nettype wire

//--- logic/led_mon_top.sv
`timescale 1ns/1ps
`default_nettype none

module led_mon_top #(
    parameter int SYNC_STAGES = 2
) (
    input  logic                 clk,
    input  logic                 SLAVE_RSTN,
    input  logic                 sck,
    input  logic                 ser,
    input  logic                 rck,
    input  led_mon_pkg::axi_ar_t ar,
    input  logic                 ar_valid,
    output logic                 ar_ready,
    output led_mon_pkg::axi_r_t  r,
    output logic                 r_valid,
    input  logic                 r_ready
);

    led_mon_pkg::seg_write_t         seg_write;
    logic [led_mon_pkg::DIGIT_W-1:0] rd_digit;
    logic [led_mon_pkg::SEG_W-1:0]   rd_seg;

    // Pin side.
    shift_chain_capture #(
        .SYNC_STAGES(SYNC_STAGES)
    ) u_capture (
        .clk       (clk),
        .SLAVE_RSTN(SLAVE_RSTN),
        .sck       (sck),
        .ser       (ser),
        .rck       (rck),
        .seg_write (seg_write)
    );

    digit_store u_store (
        .clk       (clk),
        .SLAVE_RSTN(SLAVE_RSTN),
        .seg_write (seg_write),
        .rd_digit  (rd_digit),
        .rd_seg    (rd_seg)
    );

    // Host side.
    axi_rd_slave u_axi (
        .clk       (clk),
        .SLAVE_RSTN(SLAVE_RSTN),
        .ar        (ar),
        .ar_valid  (ar_valid),
        .ar_ready  (ar_ready),
        .r         (r),
        .r_valid   (r_valid),
        .r_ready   (r_ready),
        .rd_digit  (rd_digit),
        .rd_seg    (rd_seg)
    );

endmodule

`default_nettype wire

//--- sim/led_mon_checker.sv
`timescale 1ns/1ps
`default_nettype none

module led_mon_checker (
    input  logic                 clk,
    input  logic                 SLAVE_RSTN,
    input  logic                 sck,
    input  logic                 ser,
    input  logic                 rck,
    input  led_mon_pkg::axi_ar_t ar,
    input  logic                 ar_valid,
    input  logic                 ar_ready,
    input  led_mon_pkg::axi_r_t  r,
    input  logic                 r_valid,
    input  logic                 r_ready,
    output int                   errors,
    output int                   beats
);

    logic [15:0]         chain_m;
    logic [7:0]          seg_m [32];
    logic                sck_q;
    logic                rck_q;
    logic                active;
    logic [3:0]          id_m;
    logic [31:0]         idx_m;
    logic [7:0]          len_m;
    logic [7:0]          beat_m;
    logic                stalled;
    led_mon_pkg::axi_r_t held_r;
    led_mon_pkg::axi_r_t exp_r;
    int                  err_cnt = 0;
    int                  beat_cnt = 0;

    assign errors = err_cnt;
    assign beats  = beat_cnt;

    function automatic led_mon_pkg::axi_r_t predict_beat(input logic [3:0] id,
            input logic [31:0] idx, input logic [7:0] seg, input logic last);
        led_mon_pkg::axi_r_t b;
        b.id   = id;
        b.last = last;
        if (idx < 32'd32) begin
            b.data = {19'h0, idx[4:0], seg};
            b.resp = 2'b00;
        end else begin
            b.data = 32'hffff_ffff;
            b.resp = 2'b10;
        end
        return b;
    endfunction

    task automatic compare_field(input string name, input logic [63:0] expected,
            input logic [63:0] actual);
        if (expected !== actual) begin
            $display("Mismatch %s: expected %0h, got %0h at %0t", name, expected, actual,
                     $time);
            err_cnt++;
        end
    endtask

    always @(posedge clk) begin
        if (!SLAVE_RSTN) begin
            chain_m = '0;
            for (int i = 0; i < 32; i++) begin
                seg_m[i] = '0;
            end
            sck_q   = 1'b0;
            rck_q   = 1'b0;
            active  = 1'b0;
            stalled = 1'b0;
            beat_m  = '0;
        end else begin
            // Reference shift chain and store, straight from the pins.
            if (sck && !sck_q) begin
                chain_m = {chain_m[14:0], ser};
            end
            if (rck && !rck_q) begin
                seg_m[chain_m[12:8]] = chain_m[7:0];
            end
            sck_q = sck;
            rck_q = rck;

            compare_field("r_valid", 64'(active), 64'(r_valid));
            compare_field("ar_ready", 64'(!active), 64'(ar_ready));
            if (stalled && r_valid) begin
                compare_field("r (held during stall)", 64'(held_r), 64'(r));
            end

            if (active && r_valid && r_ready) begin
                exp_r = predict_beat(id_m, idx_m, seg_m[idx_m[4:0]], beat_m == len_m);
                compare_field("r.id", 64'(exp_r.id), 64'(r.id));
                compare_field("r.data", 64'(exp_r.data), 64'(r.data));
                compare_field("r.resp", 64'(exp_r.resp), 64'(r.resp));
                compare_field("r.last", 64'(exp_r.last), 64'(r.last));
                beat_cnt++;
                if (beat_m == len_m) begin
                    active = 1'b0;
                end else begin
                    beat_m = beat_m + 8'd1;
                    idx_m  = idx_m + 32'd1;
                end
            end

            stalled = r_valid && !r_ready;
            if (stalled) begin
                held_r = r;
            end

            if (ar_valid && ar_ready) begin
                active = 1'b1;
                id_m   = ar.id;
                idx_m  = ar.addr;
                len_m  = ar.len;
                beat_m = '0;
            end
        end
    end

endmodule

`default_nettype wire

//--- sim/tb_led_mon.sv
`timescale 1ns/1ps
`default_nettype none

module tb_led_mon;

    localparam int NUM_BATCHES      = 4;
    localparam int FRAMES_PER_BATCH = 8;
    localparam int BURSTS_PER_BATCH = 10;
    localparam int NUM_FRAMES       = NUM_BATCHES * FRAMES_PER_BATCH;
    // Random bursts plus six directed ones.
    localparam int NUM_BURSTS       = NUM_BATCHES * BURSTS_PER_BATCH + 6;
    localparam int WATCHDOG_CYCLES  = NUM_FRAMES * 250 + NUM_BURSTS * 60;

    logic                 clk = 1'b0;
    logic                 SLAVE_RSTN;
    logic                 sck;
    logic                 ser;
    logic                 rck;
    led_mon_pkg::axi_ar_t ar;
    logic                 ar_valid;
    logic                 ar_ready;
    led_mon_pkg::axi_r_t  r;
    logic                 r_valid;
    logic                 r_ready;
    int                   errors;
    int                   beats;
    integer               seed = 32'h805a;
    logic [4:0]           last_digit = 5'd0;

    always #4 clk = ~clk;

    led_mon_top #(
        .SYNC_STAGES(2)
    ) DUT (
        .clk       (clk),
        .SLAVE_RSTN(SLAVE_RSTN),
        .sck       (sck),
        .ser       (ser),
        .rck       (rck),
        .ar        (ar),
        .ar_valid  (ar_valid),
        .ar_ready  (ar_ready),
        .r         (r),
        .r_valid   (r_valid),
        .r_ready   (r_ready)
    );

    led_mon_checker u_checker (
        .clk       (clk),
        .SLAVE_RSTN(SLAVE_RSTN),
        .sck       (sck),
        .ser       (ser),
        .rck       (rck),
        .ar        (ar),
        .ar_valid  (ar_valid),
        .ar_ready  (ar_ready),
        .r         (r),
        .r_valid   (r_valid),
        .r_ready   (r_ready),
        .errors    (errors),
        .beats     (beats)
    );

    task automatic idle(input int cycles);
        repeat (cycles) @(posedge clk);
    endtask

    // MSB first, each sck level held 6 clocks, then an rck pulse.
    task automatic send_frame(input logic [15:0] word);
        for (int i = 15; i >= 0; i--) begin
            ser <= word[i];
            sck <= 1'b0;
            idle(6);
            sck <= 1'b1;
            idle(6);
        end
        sck <= 1'b0;
        idle(6);
        rck <= 1'b1;
        idle(6);
        rck <= 1'b0;
        idle(6);
    endtask

    task automatic send_random_frame(input logic reuse_digit);
        logic [31:0] roll;
        logic [15:0] word;
        roll = $random(seed);
        word = roll[15:0];
        // Select byte low bits name the digit.
        if (reuse_digit) begin
            word[12:8] = last_digit;
        end
        last_digit = word[12:8];
        send_frame(word);
    endtask

    task automatic run_burst(input logic [31:0] addr, input logic [7:0] len);
        logic [31:0] roll;
        logic        done;
        roll = $random(seed);
        ar <= '{id: roll[3:0], addr: addr, len: len, burst: 2'b01};
        ar_valid <= 1'b1;
        @(posedge clk);
        while (!ar_ready) begin
            @(posedge clk);
        end
        ar_valid <= 1'b0;
        done = 1'b0;
        while (!done) begin
            roll = $random(seed);
            r_ready <= roll[0];
            @(posedge clk);
            done = r_valid && r_ready && r.last;
        end
        r_ready <= 1'b0;
    endtask

    task automatic run_random_burst();
        logic [31:0] roll;
        logic [31:0] addr;
        roll = $random(seed);
        addr = roll % 32'd41;
        roll = $random(seed);
        run_burst(addr, {5'b0, roll[2:0]});
    endtask

    initial begin
        SLAVE_RSTN = 1'b0;
        sck        = 1'b0;
        ser        = 1'b0;
        rck        = 1'b0;
        ar         = '0;
        ar_valid   = 1'b0;
        r_ready    = 1'b0;
        repeat (8) @(posedge clk);
        SLAVE_RSTN <= 1'b1;
        idle(4);
        // Blank display right after reset.
        run_burst(32'd0, 8'd7);
        for (int b = 0; b < NUM_BATCHES; b++) begin
            for (int f = 0; f < FRAMES_PER_BATCH; f++) begin
                send_random_frame(f % 4 == 3);
            end
            idle(12);
            for (int k = 0; k < BURSTS_PER_BATCH; k++) begin
                run_random_burst();
            end
        end
        for (int k = 0; k < 4; k++) begin
            run_burst(32'(k * 8), 8'd7);
        end
        // Crosses the last digit into the error range.
        run_burst(32'd28, 8'd7);
        idle(4);
        $display("Beats checked: %0d, errors: %0d", beats, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: the test did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
logic/led_mon_pkg.sv
logic/shift_chain_capture.sv
logic/digit_store.sv
logic/axi_rd_slave.sv
logic/led_mon_top.sv
sim/led_mon_checker.sv
sim/tb_led_mon.sv

//--- Makefile
# Verilator build and run for the LED display monitor.

VERILATOR ?= verilator
TOP       ?= tb_led_mon
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing
PASS_MSG  ?= *** PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qF '$(PASS_MSG)' $(LOG); then \
		echo "Simulation passed, log in $(LOG)"; \
	else \
		echo "Simulation failed, log in $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
